// ==== verilog/icache_pkg.sv ====
package icache_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address and data geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int unsigned ICACHE_ADDR_WIDTH = 32;   // byte address
  localparam int unsigned ICACHE_DATA_WIDTH = 32;   // instruction word, memory bus
  localparam int unsigned ICACHE_LINE_WIDTH = 128;  // one cache line
  localparam int unsigned ICACHE_WORDS      = 4;    // words per line

  // byte offset within a line
  localparam int unsigned ICACHE_OFFSET_BITS = 4;

  // direct mapped, one line per set
  localparam int unsigned ICACHE_NO_OF_SETS = 16;
  localparam int unsigned ICACHE_IDX_BITS   = 4;

  // tag sits above index and offset
  localparam int unsigned ICACHE_TAG_LSB  = 8;
  localparam int unsigned ICACHE_TAG_BITS = 24;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // controller states
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [2:0] {
    IDLE    = 3'd0,  // waiting for a fetch or a flush
    LOOKUP  = 3'd1,  // tag compare on captured address
    REFILL  = 3'd2,  // memory reads in flight
    FILL    = 3'd3,  // write refilled line
    RESPOND = 3'd4,  // ack to fetch side
    FLUSH   = 3'd5   // clear valid bits
  } icache_state_e;

endpackage

// ==== verilog/icache_datapath.sv ====
`timescale 1ns/100ps

module icache_datapath (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,

  input  logic                                    req_latch_i,
  input  logic                                    line_we_i,
  input  logic                                    inval_i,

  input  logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] addr_i,
  input  logic [icache_pkg::ICACHE_LINE_WIDTH-1:0] line_i,

  output logic                                    hit_o,
  output logic [icache_pkg::ICACHE_DATA_WIDTH-1:0] word_o,
  output logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] line_base_o
);

  logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0]  addr_q;
  logic [icache_pkg::ICACHE_TAG_BITS-1:0]    addr_tag;
  logic [icache_pkg::ICACHE_IDX_BITS-1:0]    addr_idx;
  logic [$clog2(icache_pkg::ICACHE_WORDS)-1:0] addr_off;

  logic [icache_pkg::ICACHE_TAG_BITS-1:0]    tag_q  [icache_pkg::ICACHE_NO_OF_SETS];
  logic [icache_pkg::ICACHE_LINE_WIDTH-1:0]  data_q [icache_pkg::ICACHE_NO_OF_SETS];
  logic [icache_pkg::ICACHE_NO_OF_SETS-1:0]  valid_q;

  logic [icache_pkg::ICACHE_LINE_WIDTH-1:0]  rd_line;
  logic [icache_pkg::ICACHE_DATA_WIDTH-1:0]  word_d, word_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // captured request address
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (req_latch_i) begin
      addr_q <= addr_i;
    end
  end

  assign addr_tag = addr_q[icache_pkg::ICACHE_ADDR_WIDTH-1:icache_pkg::ICACHE_TAG_LSB];
  assign addr_idx = addr_q[icache_pkg::ICACHE_TAG_LSB-1:icache_pkg::ICACHE_OFFSET_BITS];
  assign addr_off = addr_q[icache_pkg::ICACHE_OFFSET_BITS-1:2];  // word within line

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tag, valid and line arrays
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (!rst_ni || inval_i) begin
      valid_q <= '0;
    end else if (line_we_i) begin
      valid_q[addr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (line_we_i) begin
      tag_q[addr_idx]  <= addr_tag;
      data_q[addr_idx] <= line_i;
    end
  end

  assign rd_line = data_q[addr_idx];
  assign hit_o   = valid_q[addr_idx] && (tag_q[addr_idx] == addr_tag);

  // registered read port, follows address or line one cycle later
  always_comb begin
    case (addr_off)
      2'd0:    word_d = rd_line[31:0];
      2'd1:    word_d = rd_line[63:32];
      2'd2:    word_d = rd_line[95:64];
      default: word_d = rd_line[127:96];
    endcase
  end

  always_ff @(posedge clk_i) begin
    word_q <= word_d;
  end

  assign word_o      = word_q;
  assign line_base_o = {addr_q[icache_pkg::ICACHE_ADDR_WIDTH-1:icache_pkg::ICACHE_OFFSET_BITS],
                        {icache_pkg::ICACHE_OFFSET_BITS{1'b0}}};

endmodule

// ==== verilog/icache_ctrl.sv ====
`timescale 1ns/100ps

module icache_ctrl (
  input  logic clk_i,
  input  logic rst_ni,

  // fetch side handshake
  input  logic fetch_cyc_i,
  input  logic fetch_stb_i,
  output logic fetch_ack_o,

  input  logic flush_i,

  // datapath
  input  logic hit_i,
  output logic req_latch_o,
  output logic line_we_o,
  output logic inval_o,

  // refill unit
  input  logic refill_done_i,
  output logic refill_start_o
);

  icache_pkg::icache_state_e state_q, state_d;

  logic flush_pend_q, flush_pend_d;
  logic flush_req;
  logic fetch_req;

  assign flush_req = flush_i || flush_pend_q;  // flush wins over a new fetch
  assign fetch_req = fetch_cyc_i && fetch_stb_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // state register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= icache_pkg::IDLE;
      flush_pend_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      flush_pend_q <= flush_pend_d;
    end
  end

  // remembered until FLUSH runs
  assign flush_pend_d = (state_q == icache_pkg::FLUSH) ? 1'b0 : (flush_pend_q || flush_i);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::IDLE: begin
        if (flush_req) begin
          state_d = icache_pkg::FLUSH;
        end else if (fetch_req) begin
          state_d = icache_pkg::LOOKUP;
        end
      end
      icache_pkg::LOOKUP: begin
        state_d = hit_i ? icache_pkg::RESPOND : icache_pkg::REFILL;
      end
      icache_pkg::REFILL: begin
        if (refill_done_i) begin
          state_d = icache_pkg::FILL;
        end
      end
      // look again so the word register picks up the new line
      icache_pkg::FILL:    state_d = icache_pkg::LOOKUP;
      icache_pkg::RESPOND: state_d = icache_pkg::IDLE;
      icache_pkg::FLUSH:   state_d = icache_pkg::IDLE;
      default:             state_d = icache_pkg::IDLE;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // outputs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign req_latch_o    = (state_q == icache_pkg::IDLE) && !flush_req && fetch_req;
  assign refill_start_o = (state_q == icache_pkg::LOOKUP) && !hit_i;
  assign line_we_o      = (state_q == icache_pkg::FILL);
  assign inval_o        = (state_q == icache_pkg::FLUSH);
  assign fetch_ack_o    = (state_q == icache_pkg::RESPOND);  // single cycle

endmodule

// ==== verilog/icache_refill.sv ====
`timescale 1ns/100ps

module icache_refill (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,

  input  logic                                    start_i,
  input  logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] base_addr_i,

  // wishbone classic master
  input  logic [icache_pkg::ICACHE_DATA_WIDTH-1:0] mem_dat_i,
  input  logic                                    mem_ack_i,
  output logic                                    mem_cyc_o,
  output logic                                    mem_stb_o,
  output logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] mem_adr_o,

  output logic [icache_pkg::ICACHE_LINE_WIDTH-1:0] line_o,
  output logic                                    done_o
);

  localparam logic [1:0] LAST_BEAT = 2'(icache_pkg::ICACHE_WORDS - 1);

  logic       run_q;   // refill in progress
  logic       req_q;   // bus cycle open
  logic       done_q;
  logic [1:0] beat_q;

  logic [icache_pkg::ICACHE_LINE_WIDTH-1:0] line_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // beat sequencing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      run_q  <= 1'b0;
      req_q  <= 1'b0;
      done_q <= 1'b0;
      beat_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        run_q  <= 1'b1;
        req_q  <= 1'b1;
        beat_q <= '0;
      end else if (req_q && mem_ack_i) begin
        req_q <= 1'b0;  // idle one cycle between beats
        if (beat_q == LAST_BEAT) begin
          run_q  <= 1'b0;
          done_q <= 1'b1;
        end else begin
          beat_q <= beat_q + 2'd1;
        end
      end else if (run_q && !req_q) begin
        req_q <= 1'b1;
      end
    end
  end

  // each acked word goes into its own lane
  always_ff @(posedge clk_i) begin
    if (req_q && mem_ack_i) begin
      line_q[beat_q*icache_pkg::ICACHE_DATA_WIDTH +: icache_pkg::ICACHE_DATA_WIDTH] <= mem_dat_i;
    end
  end

  assign mem_cyc_o = req_q;
  assign mem_stb_o = req_q;
  assign mem_adr_o = {base_addr_i[icache_pkg::ICACHE_ADDR_WIDTH-1:icache_pkg::ICACHE_OFFSET_BITS],
                      beat_q, 2'b00};
  assign line_o    = line_q;
  assign done_o    = done_q;

endmodule

// ==== verilog/icache_top.sv ====
`timescale 1ns/100ps

module icache_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,

  input  logic                                    flush_i,

  // fetch side, wishbone classic slave
  input  logic                                    fetch_cyc_i,
  input  logic                                    fetch_stb_i,
  input  logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] fetch_adr_i,
  output logic [icache_pkg::ICACHE_DATA_WIDTH-1:0] fetch_dat_o,
  output logic                                    fetch_ack_o,

  // memory side, wishbone classic master
  output logic                                    mem_cyc_o,
  output logic                                    mem_stb_o,
  output logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] mem_adr_o,
  input  logic [icache_pkg::ICACHE_DATA_WIDTH-1:0] mem_dat_i,
  input  logic                                    mem_ack_i
);

  logic hit;
  logic req_latch;
  logic line_we;
  logic inval;
  logic refill_start;
  logic refill_done;

  logic [icache_pkg::ICACHE_LINE_WIDTH-1:0] refill_line;
  logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] line_base;

  icache_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_cyc_i    (fetch_cyc_i),
    .fetch_stb_i    (fetch_stb_i),
    .fetch_ack_o    (fetch_ack_o),
    .flush_i        (flush_i),
    .hit_i          (hit),
    .req_latch_o    (req_latch),
    .line_we_o      (line_we),
    .inval_o        (inval),
    .refill_done_i  (refill_done),
    .refill_start_o (refill_start)
  );

  icache_datapath u_datapath (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_latch_i (req_latch),
    .line_we_i   (line_we),
    .inval_i     (inval),
    .addr_i      (fetch_adr_i),
    .line_i      (refill_line),
    .hit_o       (hit),
    .word_o      (fetch_dat_o),
    .line_base_o (line_base)
  );

  icache_refill u_refill (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (refill_start),
    .base_addr_i (line_base),
    .mem_dat_i   (mem_dat_i),
    .mem_ack_i   (mem_ack_i),
    .mem_cyc_o   (mem_cyc_o),
    .mem_stb_o   (mem_stb_o),
    .mem_adr_o   (mem_adr_o),
    .line_o      (refill_line),
    .done_o      (refill_done)
  );

endmodule

// ==== sim/icache_tb.sv ====
`timescale 1ns/100ps

module icache_tb;

  localparam int HIT_LATENCY    = 2;  // cycles from stb driven to ack seen
  localparam int N_RANDOM       = 40;
  localparam int OP_FETCH       = 0;
  localparam int OP_FLUSH       = 1;
  localparam int OP_FETCH_FLUSH = 2;  // fetch with a flush during its refill
  localparam logic [31:0] MEM_PATTERN = 32'h5a3c_96e1;
  localparam logic [31:0] RAND_BASE   = 32'h0000_3000;
  localparam int unsigned RAND_SPAN   = 512;  // 32 lines over two tags per set

  logic clk_i = 1'b0;
  logic rst_ni, flush_i, fetch_cyc_i, fetch_stb_i, fetch_ack_o;
  logic mem_cyc_o, mem_stb_o;
  logic mem_ack_i = 1'b0;
  logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] fetch_adr_i, mem_adr_o, rnd_adr;
  logic [icache_pkg::ICACHE_DATA_WIDTH-1:0] fetch_dat_o;
  logic [icache_pkg::ICACHE_DATA_WIDTH-1:0] mem_dat_i = '0;

  int errors = 0;
  int bus_errors = 0;
  int cycles = 0;
  int cycle_limit = 0;
  int mem_total = 0;
  int unsigned mem_seed = 88142;
  int unsigned rnd_seed = 88142;
  int unsigned wait_cnt;
  bit mem_busy = 1'b0;

  logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] adr_log [$];  // acked memory addresses
  int                                       tab_op [$];
  logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] tab_adr [$];
  logic                                     tab_miss [$];

  logic [icache_pkg::ICACHE_TAG_BITS-1:0]   shadow_tag [icache_pkg::ICACHE_NO_OF_SETS];
  logic [icache_pkg::ICACHE_NO_OF_SETS-1:0] shadow_valid;

  icache_top dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .fetch_cyc_i (fetch_cyc_i),
    .fetch_stb_i (fetch_stb_i),
    .fetch_adr_i (fetch_adr_i),
    .fetch_dat_o (fetch_dat_o),
    .fetch_ack_o (fetch_ack_o),
    .mem_cyc_o   (mem_cyc_o),
    .mem_stb_o   (mem_stb_o),
    .mem_adr_o   (mem_adr_o),
    .mem_dat_i   (mem_dat_i),
    .mem_ack_i   (mem_ack_i)
  );

  always #2 clk_i = ~clk_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference models
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic int unsigned lcg_next(input int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] adr);
    return adr ^ MEM_PATTERN;
  endfunction

  function automatic logic shadow_miss(input logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] adr);
    logic [icache_pkg::ICACHE_IDX_BITS-1:0] idx;
    idx = adr[icache_pkg::ICACHE_TAG_LSB-1:icache_pkg::ICACHE_OFFSET_BITS];
    return !(shadow_valid[idx] &&
             shadow_tag[idx] == adr[icache_pkg::ICACHE_ADDR_WIDTH-1:icache_pkg::ICACHE_TAG_LSB]);
  endfunction

  // wishbone classic slave with 0 to 2 wait states per beat
  always @(posedge clk_i) begin
    #1;
    if (mem_ack_i) begin
      mem_ack_i = 1'b0;
      mem_busy  = 1'b0;
      check_flag("mem_cyc_o", mem_cyc_o, 1'b0);  // idle cycle after each beat
      check_flag("mem_stb_o", mem_stb_o, 1'b0);
    end else if (mem_cyc_o === 1'b1 && mem_stb_o === 1'b1) begin
      if (!mem_busy) begin
        mem_busy = 1'b1;
        mem_seed = lcg_next(mem_seed);
        wait_cnt = (mem_seed >> 16) % 3;
      end
      if (wait_cnt == 0) begin
        mem_dat_i = mem_word(mem_adr_o);
        mem_ack_i = 1'b1;
        adr_log.push_back(mem_adr_o);
        mem_total++;
      end else begin
        wait_cnt--;
      end
    end else if (mem_busy) begin
      $display("error: memory cycle at %h was dropped before its ack", mem_adr_o);
      bus_errors++;
      mem_busy = 1'b0;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic check_word(input string name, input logic [icache_pkg::ICACHE_DATA_WIDTH-1:0] got,
                            input logic [icache_pkg::ICACHE_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] got,
                            input logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus operations
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic run_fetch(input logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] adr,
                           input logic exp_miss, input bit flush_mid);
    logic [icache_pkg::ICACHE_IDX_BITS-1:0]   idx;
    logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] base;
    int lat;
    int first_beat;
    int beats;
    bit flush_sent;
    idx  = adr[icache_pkg::ICACHE_TAG_LSB-1:icache_pkg::ICACHE_OFFSET_BITS];
    base = {adr[icache_pkg::ICACHE_ADDR_WIDTH-1:icache_pkg::ICACHE_OFFSET_BITS], 4'h0};
    @(posedge clk_i);
    #1;
    first_beat  = mem_total;
    flush_sent  = 1'b0;
    lat         = 0;
    fetch_cyc_i = 1'b1;
    fetch_stb_i = 1'b1;
    fetch_adr_i = adr;
    do begin
      @(posedge clk_i);
      #1;
      lat++;
      flush_i = 1'b0;
      if (flush_mid && !flush_sent && mem_cyc_o) begin
        flush_i    = 1'b1;  // one pulse while the refill is busy
        flush_sent = 1'b1;
      end
    end while (!fetch_ack_o);
    fetch_cyc_i = 1'b0;
    fetch_stb_i = 1'b0;
    flush_i     = 1'b0;
    beats = mem_total - first_beat;
    check_word("fetch_dat_o", fetch_dat_o, mem_word(adr));
    check_flag("hit", lat == HIT_LATENCY, !exp_miss);
    check_count("memory cycles", beats, exp_miss ? int'(icache_pkg::ICACHE_WORDS) : 0);
    for (int k = 0; k < beats && k < int'(icache_pkg::ICACHE_WORDS); k++) begin
      check_addr("mem_adr_o", adr_log[first_beat + k], base + 32'(4 * k));
    end
    shadow_valid[idx] = 1'b1;
    shadow_tag[idx]   = adr[icache_pkg::ICACHE_ADDR_WIDTH-1:icache_pkg::ICACHE_TAG_LSB];
    if (flush_mid) begin
      shadow_valid = '0;  // pending flush runs after the ack
    end
  endtask

  task automatic run_flush();
    @(posedge clk_i);
    #1;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    check_flag("fetch_ack_o", fetch_ack_o, 1'b0);
    shadow_valid = '0;
  endtask

  task automatic add_entry(input int op, input logic [icache_pkg::ICACHE_ADDR_WIDTH-1:0] adr,
                           input logic miss);
    tab_op.push_back(op);
    tab_adr.push_back(adr);
    tab_miss.push_back(miss);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    fetch_cyc_i  = 1'b0;
    fetch_stb_i  = 1'b0;
    fetch_adr_i  = '0;
    shadow_valid = '0;
    add_entry(OP_FETCH, 32'h0000_1040, 1'b1);        // cold miss
    add_entry(OP_FETCH, 32'h0000_1040, 1'b0);
    add_entry(OP_FETCH, 32'h0000_1044, 1'b0);
    add_entry(OP_FETCH, 32'h0000_1048, 1'b0);
    add_entry(OP_FETCH, 32'h0000_104c, 1'b0);
    add_entry(OP_FETCH, 32'h0000_2040, 1'b1);        // same set with a new tag
    add_entry(OP_FETCH, 32'h0000_2048, 1'b0);
    add_entry(OP_FETCH, 32'h0000_1044, 1'b1);        // evicted
    add_entry(OP_FETCH, 32'h0000_1080, 1'b1);
    add_entry(OP_FLUSH, 32'h0000_0000, 1'b0);
    add_entry(OP_FETCH, 32'h0000_1044, 1'b1);
    add_entry(OP_FETCH_FLUSH, 32'h0000_1088, 1'b1);
    add_entry(OP_FETCH, 32'h0000_1048, 1'b1);        // gone after the late flush
    cycle_limit = 64 * (tab_op.size() + N_RANDOM);
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    repeat (3) begin
      @(posedge clk_i);
      #1;
      check_flag("fetch_ack_o", fetch_ack_o, 1'b0);
      check_flag("mem_cyc_o", mem_cyc_o, 1'b0);
      check_flag("mem_stb_o", mem_stb_o, 1'b0);
    end
    foreach (tab_op[i]) begin
      if (tab_op[i] == OP_FLUSH) begin
        run_flush();
      end else begin
        check_flag("table refill flag", shadow_miss(tab_adr[i]), tab_miss[i]);
        run_fetch(tab_adr[i], tab_miss[i], tab_op[i] == OP_FETCH_FLUSH);
      end
    end
    for (int n = 0; n < N_RANDOM; n++) begin
      rnd_seed     = lcg_next(rnd_seed);
      rnd_adr      = RAND_BASE + ((rnd_seed >> 8) % RAND_SPAN);
      rnd_adr[1:0] = 2'b00;
      run_fetch(rnd_adr, shadow_miss(rnd_adr), 1'b0);
    end
    $display("errors: %0d mismatches, %0d bus protocol errors", errors, bus_errors);
    if (errors == 0 && bus_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    @(posedge clk_i);
    while (cycles < cycle_limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("error: timeout after %0d cycles, controller in state %0d",
             cycles, dut.u_ctrl.state_q);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== filelist.f ====
verilog/icache_pkg.sv
verilog/icache_datapath.sv
verilog/icache_ctrl.sv
verilog/icache_refill.sv
verilog/icache_top.sv
sim/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module icache_tb -o icache_sim \
  && ./obj_dir/icache_sim | tee /dev/stderr | grep -qx '>>> PASS' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
